// ==== csr_unit.f ====
design/csr_pkg.sv
design/trap_ctrl.sv
design/csr_access.sv
design/interrupt_unit.sv
design/trap_regs.sv
design/csr_unit_top.sv
tb/csr_unit_tb.sv

// ==== design/csr_access.sv ====
`timescale 1ns/1ns

module csr_access (
    input  logic                           valid,
    input  csr_pkg::csr_cmd_t              cmd,
    input  logic [csr_pkg::csr_addr_w-1:0] csr_addr,
    input  logic [csr_pkg::xlen-1:0]       op1_data,
    input  csr_pkg::mode_t                 mode,
    input  logic [csr_pkg::xlen-1:0]       rdata_ctrl,
    input  logic [csr_pkg::xlen-1:0]       rdata_int,
    input  logic [csr_pkg::xlen-1:0]       rdata_m,
    input  logic [csr_pkg::xlen-1:0]       rdata_s,
    output logic                           wr_en,
    output logic [csr_pkg::csr_addr_w-1:0] wr_addr,
    output logic [csr_pkg::xlen-1:0]       wdata,
    output logic [csr_pkg::xlen-1:0]       rdata
);

    logic access_ok;
    logic write_ok;
    logic is_wr_cmd;

    // Address bits 9:8 give the lowest privilege allowed
    assign access_ok = csr_addr[9:8] <= mode;
    assign write_ok  = access_ok && csr_addr[11:10] != 2'b11; // 11 means read-only
    assign is_wr_cmd = cmd inside {csr_pkg::cmd_write, csr_pkg::cmd_set, csr_pkg::cmd_clear};

    // Non-owners return zero so OR is enough
    assign rdata = access_ok ? (rdata_ctrl | rdata_int | rdata_m | rdata_s) : '0;

    always_comb begin
        case (cmd)
            csr_pkg::cmd_write: wdata = op1_data;
            csr_pkg::cmd_set:   wdata = rdata | op1_data;
            csr_pkg::cmd_clear: wdata = rdata & ~op1_data;
            default:            wdata = '0;
        endcase
    end

    assign wr_en   = valid && is_wr_cmd && write_ok;
    assign wr_addr = csr_addr;

    // At most one module owns any address
    read_owner_a: assert final ($onehot0({|rdata_ctrl, |rdata_int, |rdata_m, |rdata_s}));

endmodule

// ==== design/csr_pkg.sv ====
package csr_pkg;

    localparam int xlen       = 32;
    localparam int csr_addr_w = 12;

    // Privilege levels, hypervisor code 2 unused
    typedef enum logic [1:0] {
        mode_user    = 2'd0,
        mode_super   = 2'd1,
        mode_machine = 2'd3
    } mode_t;

    typedef enum logic [2:0] {
        cmd_none  = 3'd0,
        cmd_write = 3'd1,
        cmd_set   = 3'd2,
        cmd_clear = 3'd3,
        cmd_ecall = 3'd4, // Trap class, top bit set
        cmd_mret  = 3'd5,
        cmd_sret  = 3'd6
    } csr_cmd_t;

    // Machine trap setup and handling
    localparam logic [csr_addr_w-1:0] addr_mstatus  = 12'h300;
    localparam logic [csr_addr_w-1:0] addr_misa     = 12'h301;
    localparam logic [csr_addr_w-1:0] addr_medeleg  = 12'h302;
    localparam logic [csr_addr_w-1:0] addr_mideleg  = 12'h303;
    localparam logic [csr_addr_w-1:0] addr_mie      = 12'h304;
    localparam logic [csr_addr_w-1:0] addr_mtvec    = 12'h305;
    localparam logic [csr_addr_w-1:0] addr_mstatush = 12'h310;
    localparam logic [csr_addr_w-1:0] addr_mscratch = 12'h340;
    localparam logic [csr_addr_w-1:0] addr_mepc     = 12'h341;
    localparam logic [csr_addr_w-1:0] addr_mcause   = 12'h342;
    localparam logic [csr_addr_w-1:0] addr_mip      = 12'h344;
    // Supervisor views
    localparam logic [csr_addr_w-1:0] addr_sstatus  = 12'h100;
    localparam logic [csr_addr_w-1:0] addr_sie      = 12'h104;
    localparam logic [csr_addr_w-1:0] addr_stvec    = 12'h105;
    localparam logic [csr_addr_w-1:0] addr_sscratch = 12'h140;
    localparam logic [csr_addr_w-1:0] addr_sepc     = 12'h141;
    localparam logic [csr_addr_w-1:0] addr_scause   = 12'h142;
    localparam logic [csr_addr_w-1:0] addr_sip      = 12'h144;

    // Interrupt causes, top bit marks interrupt
    localparam logic [xlen-1:0] cause_mei = 32'h8000_000B;
    localparam logic [xlen-1:0] cause_msi = 32'h8000_0003;
    localparam logic [xlen-1:0] cause_mti = 32'h8000_0007;
    localparam logic [xlen-1:0] cause_sei = 32'h8000_0009;
    localparam logic [xlen-1:0] cause_ssi = 32'h8000_0001;
    localparam logic [xlen-1:0] cause_sti = 32'h8000_0005;

    localparam logic [xlen-1:0] cause_ecall_u = 32'd8; // Plus mode gives S 9, M 11

    // MXL 32, extensions M, I, A
    localparam logic [xlen-1:0] misa_value = 32'h4000_1101;

    localparam logic [1:0] tvec_vectored = 2'b01;

    // Implemented interrupt bits, all six and the supervisor three
    localparam logic [xlen-1:0] irq_mask  = 32'h0000_0AAA;
    localparam logic [xlen-1:0] sirq_mask = 32'h0000_0222;

endpackage

// ==== design/csr_unit_top.sv ====
`timescale 1ns/1ns

module csr_unit_top (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           valid,
    input  logic [csr_pkg::xlen-1:0]       pc,
    input  csr_pkg::csr_cmd_t              cmd,
    input  logic [csr_pkg::csr_addr_w-1:0] csr_addr,
    input  logic [csr_pkg::xlen-1:0]       op1_data,
    input  logic [63:0]                    mtime,
    input  logic [63:0]                    mtimecmp,
    output logic [csr_pkg::xlen-1:0]       rdata,
    output logic                           trap_flg,
    output logic [csr_pkg::xlen-1:0]       trap_vector
);

    csr_pkg::mode_t                 mode;
    logic                           trap_take;
    logic                           trap_to_m;
    logic [csr_pkg::xlen-1:0]       trap_cause;
    // Broadcast write bus
    logic                           wr_en;
    logic [csr_pkg::csr_addr_w-1:0] wr_addr;
    logic [csr_pkg::xlen-1:0]       wdata;
    // Per-module read returns
    logic [csr_pkg::xlen-1:0]       rdata_ctrl;
    logic [csr_pkg::xlen-1:0]       rdata_int;
    logic [csr_pkg::xlen-1:0]       rdata_m;
    logic [csr_pkg::xlen-1:0]       rdata_s;
    logic                           int_pending;
    logic [csr_pkg::xlen-1:0]       int_cause;
    logic                           int_to_m;
    logic                           exc_to_m;
    logic [csr_pkg::xlen-1:0]       m_vec_addr;
    logic [csr_pkg::xlen-1:0]       s_vec_addr;
    logic [csr_pkg::xlen-1:0]       mepc;
    logic [csr_pkg::xlen-1:0]       sepc;

    trap_ctrl u_trap_ctrl (
        .clk, .arst_n, .valid, .cmd, .wr_en, .wr_addr, .wdata,
        .int_pending, .int_cause, .int_to_m, .exc_to_m,
        .m_vec_addr, .s_vec_addr, .mepc, .sepc, .csr_addr,
        .mode, .trap_take, .trap_to_m, .trap_cause, .trap_flg, .trap_vector,
        .rdata(rdata_ctrl)
    );

    csr_access u_csr_access (
        .valid, .cmd, .csr_addr, .op1_data, .mode,
        .rdata_ctrl, .rdata_int, .rdata_m, .rdata_s,
        .wr_en, .wr_addr, .wdata, .rdata
    );

    interrupt_unit u_interrupt_unit (
        .clk, .arst_n, .valid, .trap_take, .mode, .mtime, .mtimecmp,
        .wr_en, .wr_addr, .wdata, .csr_addr,
        .int_pending, .int_cause, .int_to_m, .exc_to_m, .rdata(rdata_int)
    );

    trap_regs #(.level(csr_pkg::mode_machine)) u_trap_m (
        .clk, .arst_n, .trap_take, .trap_to_m, .trap_cause, .pc, .int_cause,
        .wr_en, .wr_addr, .wdata, .csr_addr,
        .vec_addr(m_vec_addr), .epc(mepc), .rdata(rdata_m)
    );

    trap_regs #(.level(csr_pkg::mode_super)) u_trap_s (
        .clk, .arst_n, .trap_take, .trap_to_m, .trap_cause, .pc, .int_cause,
        .wr_en, .wr_addr, .wdata, .csr_addr,
        .vec_addr(s_vec_addr), .epc(sepc), .rdata(rdata_s)
    );

endmodule

// ==== design/interrupt_unit.sv ====
`timescale 1ns/1ns

module interrupt_unit (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           valid,
    input  logic                           trap_take,
    input  csr_pkg::mode_t                 mode,
    input  logic [63:0]                    mtime,
    input  logic [63:0]                    mtimecmp,
    input  logic                           wr_en,
    input  logic [csr_pkg::csr_addr_w-1:0] wr_addr,
    input  logic [csr_pkg::xlen-1:0]       wdata,
    input  logic [csr_pkg::csr_addr_w-1:0] csr_addr,
    output logic                           int_pending,
    output logic [csr_pkg::xlen-1:0]       int_cause,
    output logic                           int_to_m,
    output logic                           exc_to_m,
    output logic [csr_pkg::xlen-1:0]       rdata
);

    logic [csr_pkg::xlen-1:0] mie_r;
    logic [csr_pkg::xlen-1:0] mip_r;
    logic [csr_pkg::xlen-1:0] mideleg_r;
    logic [csr_pkg::xlen-1:0] medeleg_r;
    logic [csr_pkg::xlen-1:0] irq_en;
    logic [4:0]               ecall_code;

    assign irq_en      = mip_r & mie_r; // Pending and enabled
    assign int_pending = |irq_en;

    // Fixed order MEI, MSI, MTI, SEI, SSI, STI
    always_comb begin
        if (irq_en[11])     int_cause = csr_pkg::cause_mei;
        else if (irq_en[3]) int_cause = csr_pkg::cause_msi;
        else if (irq_en[7]) int_cause = csr_pkg::cause_mti;
        else if (irq_en[9]) int_cause = csr_pkg::cause_sei;
        else if (irq_en[1]) int_cause = csr_pkg::cause_ssi;
        else if (irq_en[5]) int_cause = csr_pkg::cause_sti;
        else                int_cause = '0;
    end

    // Delegation lookup by cause number
    assign int_to_m   = !mideleg_r[int_cause[4:0]];
    assign ecall_code = csr_pkg::cause_ecall_u[4:0] + {3'b0, mode};
    assign exc_to_m   = !medeleg_r[ecall_code];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mie_r     <= '0;
            mip_r     <= '0;
            mideleg_r <= '0;
            medeleg_r <= '0;
        end else begin
            if (valid && !trap_take)
                mip_r[7] <= mtime >= mtimecmp; // mtip sample
            if (wr_en) begin
                case (wr_addr)
                    csr_pkg::addr_medeleg: medeleg_r <= wdata;
                    csr_pkg::addr_mideleg: mideleg_r <= wdata & csr_pkg::irq_mask;
                    csr_pkg::addr_mie:     mie_r     <= wdata & csr_pkg::irq_mask;
                    csr_pkg::addr_sie:
                        mie_r <= (mie_r & ~csr_pkg::sirq_mask) | (wdata & csr_pkg::sirq_mask);
                    csr_pkg::addr_mip, csr_pkg::addr_sip: begin
                        mip_r[9] <= wdata[9]; // Only S bits writable
                        mip_r[5] <= wdata[5];
                        mip_r[1] <= wdata[1];
                    end
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        case (csr_addr)
            csr_pkg::addr_medeleg: rdata = medeleg_r;
            csr_pkg::addr_mideleg: rdata = mideleg_r;
            csr_pkg::addr_mie:     rdata = mie_r;
            csr_pkg::addr_sie:     rdata = mie_r & csr_pkg::sirq_mask;
            csr_pkg::addr_mip:     rdata = mip_r;
            csr_pkg::addr_sip:     rdata = mip_r & csr_pkg::sirq_mask;
            default:               rdata = '0;
        endcase
    end

    int_cause_a: assert property (@(posedge clk) disable iff (!arst_n)
        int_pending |-> int_cause[csr_pkg::xlen-1]);

endmodule

// ==== design/trap_ctrl.sv ====
`timescale 1ns/1ns

module trap_ctrl (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           valid,
    input  csr_pkg::csr_cmd_t              cmd,
    input  logic                           wr_en,
    input  logic [csr_pkg::csr_addr_w-1:0] wr_addr,
    input  logic [csr_pkg::xlen-1:0]       wdata,
    input  logic                           int_pending,
    input  logic [csr_pkg::xlen-1:0]       int_cause,
    input  logic                           int_to_m,
    input  logic                           exc_to_m,
    input  logic [csr_pkg::xlen-1:0]       m_vec_addr,
    input  logic [csr_pkg::xlen-1:0]       s_vec_addr,
    input  logic [csr_pkg::xlen-1:0]       mepc,
    input  logic [csr_pkg::xlen-1:0]       sepc,
    input  logic [csr_pkg::csr_addr_w-1:0] csr_addr,
    output csr_pkg::mode_t                 mode,
    output logic                           trap_take,
    output logic                           trap_to_m,
    output logic [csr_pkg::xlen-1:0]       trap_cause,
    output logic                           trap_flg,
    output logic [csr_pkg::xlen-1:0]       trap_vector,
    output logic [csr_pkg::xlen-1:0]       rdata
);

    // Status stack
    logic [1:0]               mpp;
    logic                     spp;
    logic                     mpie;
    logic                     spie;
    logic                     mie;
    logic                     sie;
    logic                     is_ecall;
    logic                     int_en;
    logic                     ret_m;
    logic                     ret_s;
    logic [csr_pkg::xlen-1:0] mstatus;
    logic [csr_pkg::xlen-1:0] sstatus;

    assign is_ecall = valid && cmd == csr_pkg::cmd_ecall;

    // Global enable of the target level
    assign int_en = int_to_m ? (mode != csr_pkg::mode_machine || mie)
                             : (mode == csr_pkg::mode_user ||
                                (mode == csr_pkg::mode_super && sie));

    assign trap_take  = is_ecall || (valid && int_pending && int_en);
    assign trap_to_m  = mode == csr_pkg::mode_machine || (is_ecall ? exc_to_m : int_to_m);
    assign trap_cause = is_ecall ? csr_pkg::cause_ecall_u + {30'b0, mode} : int_cause;

    assign ret_m    = valid && !trap_take && cmd == csr_pkg::cmd_mret;
    assign ret_s    = valid && !trap_take && cmd == csr_pkg::cmd_sret;
    assign trap_flg = trap_take || ret_m || ret_s;

    assign mstatus = {19'b0, mpp, 2'b0, spp, mpie, 1'b0, spie, 1'b0, mie, 1'b0, sie, 1'b0};
    assign sstatus = {23'b0, spp, 2'b0, spie, 3'b0, sie, 1'b0}; // S-visible subset

    always_comb begin
        case (csr_addr)
            csr_pkg::addr_mstatus:  rdata = mstatus;
            csr_pkg::addr_sstatus:  rdata = sstatus;
            csr_pkg::addr_misa:     rdata = csr_pkg::misa_value;
            csr_pkg::addr_mstatush: rdata = '0; // Little endian only
            default:                rdata = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mode        <= csr_pkg::mode_machine;
            mpp         <= csr_pkg::mode_machine;
            spp         <= 1'b0;
            mpie        <= 1'b0;
            spie        <= 1'b0;
            mie         <= 1'b0;
            sie         <= 1'b0;
            trap_vector <= '0;
        end else if (trap_take) begin
            if (trap_to_m) begin
                mode        <= csr_pkg::mode_machine;
                mpie        <= mie; // Push enable
                mie         <= 1'b0;
                mpp         <= mode;
                trap_vector <= m_vec_addr;
            end else begin
                mode        <= csr_pkg::mode_super;
                spie        <= sie;
                sie         <= 1'b0;
                spp         <= mode[0]; // Only U or S reach here
                trap_vector <= s_vec_addr;
            end
        end else if (ret_m) begin
            mode        <= csr_pkg::mode_t'(mpp); // Pop
            mie         <= mpie;
            mpie        <= 1'b1;
            mpp         <= csr_pkg::mode_user;
            trap_vector <= mepc;
        end else if (ret_s) begin
            mode        <= csr_pkg::mode_t'({1'b0, spp});
            sie         <= spie;
            spie        <= 1'b1;
            spp         <= 1'b0;
            trap_vector <= sepc;
        end else if (wr_en) begin
            case (wr_addr)
                csr_pkg::addr_mstatus: begin
                    mpp  <= wdata[12:11];
                    spp  <= wdata[8];
                    mpie <= wdata[7];
                    spie <= wdata[5];
                    mie  <= wdata[3];
                    sie  <= wdata[1];
                end
                csr_pkg::addr_sstatus: begin // Leaves M fields alone
                    spp  <= wdata[8];
                    spie <= wdata[5];
                    sie  <= wdata[1];
                end
                default: ;
            endcase
        end
    end

    // A trap never lowers privilege
    trap_no_demote_a: assert property (@(posedge clk) disable iff (!arst_n)
        trap_take |=> mode >= $past(mode));

endmodule

// ==== design/trap_regs.sv ====
`timescale 1ns/1ns

module trap_regs #(
    parameter csr_pkg::mode_t level = csr_pkg::mode_machine
) (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           trap_take,
    input  logic                           trap_to_m,
    input  logic [csr_pkg::xlen-1:0]       trap_cause,
    input  logic [csr_pkg::xlen-1:0]       pc,
    input  logic [csr_pkg::xlen-1:0]       int_cause,
    input  logic                           wr_en,
    input  logic [csr_pkg::csr_addr_w-1:0] wr_addr,
    input  logic [csr_pkg::xlen-1:0]       wdata,
    input  logic [csr_pkg::csr_addr_w-1:0] csr_addr,
    output logic [csr_pkg::xlen-1:0]       vec_addr,
    output logic [csr_pkg::xlen-1:0]       epc,
    output logic [csr_pkg::xlen-1:0]       rdata
);

    localparam logic is_m = level == csr_pkg::mode_machine;
    // Address map of this bank
    localparam logic [csr_pkg::csr_addr_w-1:0] a_tvec    =
        is_m ? csr_pkg::addr_mtvec : csr_pkg::addr_stvec;
    localparam logic [csr_pkg::csr_addr_w-1:0] a_scratch =
        is_m ? csr_pkg::addr_mscratch : csr_pkg::addr_sscratch;
    localparam logic [csr_pkg::csr_addr_w-1:0] a_epc     =
        is_m ? csr_pkg::addr_mepc : csr_pkg::addr_sepc;
    localparam logic [csr_pkg::csr_addr_w-1:0] a_cause   =
        is_m ? csr_pkg::addr_mcause : csr_pkg::addr_scause;
    localparam logic [csr_pkg::xlen-1:0] epc_mask = is_m ? 32'hFFFF_FFFC : 32'hFFFF_FFFF;

    logic [csr_pkg::xlen-1:0] tvec;
    logic [csr_pkg::xlen-1:0] scratch;
    logic [csr_pkg::xlen-1:0] cause;
    logic [csr_pkg::xlen-1:0] base;
    logic [csr_pkg::xlen-1:0] offset;
    logic                     take_here;

    assign take_here = trap_take && (trap_to_m == is_m);

    // Vectored mode offsets interrupts only, exceptions go to base
    assign base     = {tvec[csr_pkg::xlen-1:2], 2'b00};
    assign offset   = trap_cause[csr_pkg::xlen-1] ? {int_cause[csr_pkg::xlen-3:0], 2'b00} : '0;
    assign vec_addr = tvec[1:0] == csr_pkg::tvec_vectored ? base + offset : base;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tvec    <= '0;
            scratch <= '0;
            epc     <= '0;
            cause   <= '0;
        end else if (take_here) begin
            epc   <= pc & epc_mask;
            cause <= trap_cause;
        end else if (wr_en) begin
            case (wr_addr)
                a_tvec:    tvec    <= wdata;
                a_scratch: scratch <= wdata;
                a_epc:     epc     <= wdata & epc_mask;
                a_cause:   cause   <= wdata;
                default: ;
            endcase
        end
    end

    always_comb begin
        case (csr_addr)
            a_tvec:    rdata = tvec;
            a_scratch: rdata = scratch;
            a_epc:     rdata = epc;
            a_cause:   rdata = cause;
            default:   rdata = '0;
        endcase
    end

    if (is_m) begin : g_epc_align
        epc_align_a: assert property (@(posedge clk) disable iff (!arst_n) epc[1:0] == 2'b00);
    end

endmodule

// ==== tb/csr_unit_tb.sv ====
`timescale 1ns/1ns

module csr_unit_tb;

    localparam int clk_period      = 8;
    localparam int est_cycles      = 500;            // Six tests with resets, generous
    localparam int watchdog_cycles = 4 * est_cycles;

    logic              clk;
    logic              arst_n;
    logic              valid;
    logic [31:0]       pc;
    csr_pkg::csr_cmd_t cmd;
    logic [11:0]       csr_addr;
    logic [31:0]       op1_data;
    logic [63:0]       mtime;
    logic [63:0]       mtimecmp;
    logic [31:0]       rdata;
    logic              trap_flg;
    logic [31:0]       trap_vector;

    integer seed;
    int     errors;
    int     checks;
    int     test_errors; // Error count when the current test began

    csr_unit_top u_dut (
        .clk, .arst_n, .valid, .pc, .cmd, .csr_addr, .op1_data, .mtime, .mtimecmp,
        .rdata, .trap_flg, .trap_vector
    );

    always #(clk_period / 2) clk = ~clk;

    initial begin
        #(watchdog_cycles * clk_period);
        $display("Watchdog expired after %0d cycles, tests did not complete", watchdog_cycles);
        $display("Test failures found");
        $finish;
    end

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp)
        else begin
            $display("Mismatch %s: got 0x%08h expected 0x%08h", name, got, exp);
            errors++;
        end
    endtask

    // One valid cycle, outputs sampled mid low phase
    task automatic issue_cmd(input csr_pkg::csr_cmd_t c, input logic [11:0] addr,
                             input logic [31:0] data, input logic [31:0] pc_in,
                             output logic [31:0] rd, output logic flg);
        @(negedge clk);
        valid    = 1'b1;
        cmd      = c;
        csr_addr = addr;
        op1_data = data;
        pc       = pc_in;
        #(clk_period / 4);
        rd  = rdata;
        flg = trap_flg;
        @(negedge clk);
        valid = 1'b0;
        cmd   = csr_pkg::cmd_none;
    endtask

    // Write, set or clear
    task automatic modify_csr(input csr_pkg::csr_cmd_t c, input logic [11:0] addr,
                              input logic [31:0] data);
        logic [31:0] rd;
        logic        flg;
        issue_cmd(c, addr, data, 32'h0, rd, flg);
    endtask

    task automatic read_csr(input logic [11:0] addr, output logic [31:0] rd);
        logic flg;
        issue_cmd(csr_pkg::cmd_none, addr, 32'h0, 32'h0, rd, flg);
    endtask

    task automatic expect_csr(input string name, input logic [11:0] addr,
                              input logic [31:0] exp);
        logic [31:0] rd;
        read_csr(addr, rd);
        compare(name, rd, exp);
    endtask

    // Trap-class or plain command at a given pc
    task automatic run_cmd(input csr_pkg::csr_cmd_t c, input logic [31:0] pc_in,
                           input logic exp_flg);
        logic [31:0] rd;
        logic        flg;
        issue_cmd(c, 12'h000, 32'h0, pc_in, rd, flg);
        compare("trap_flg", {31'b0, flg}, {31'b0, exp_flg});
    endtask

    // mtimecmp kept above 2**62 so the offset never wraps
    task automatic set_timer(input logic fire);
        logic [31:0] lo;
        logic [31:0] hi;
        logic [63:0] delta;
        lo       = $random(seed);
        hi       = $random(seed);
        delta    = {48'b0, lo[15:0]};
        mtimecmp = {2'b01, hi[29:0], lo};
        mtime    = fire ? mtimecmp + delta : mtimecmp - delta - 64'd1;
    endtask

    // Every test starts here, so the error baseline is taken too
    task automatic apply_reset();
        @(negedge clk);
        arst_n      = 1'b0;
        test_errors = errors;
        set_timer(1'b0);
        repeat (8) @(negedge clk);
        arst_n = 1'b1;
    endtask

    task automatic report_test(input string name);
        if (errors == test_errors)
            $display("%s: ok", name);
        else
            $display("%s: %0d errors", name, errors - test_errors);
    endtask

    task automatic rw_set_clear();
        logic [31:0] val;
        logic [31:0] sval;
        apply_reset();
        val  = $random(seed);
        sval = ~val ^ 32'h0000_5a5a; // Differs from mscratch in every bit pattern
        modify_csr(csr_pkg::cmd_write, csr_pkg::addr_mscratch, val);
        expect_csr("mscratch", csr_pkg::addr_mscratch, val);
        modify_csr(csr_pkg::cmd_set, csr_pkg::addr_mscratch, 32'h0f00_00f0);
        val = val | 32'h0f00_00f0;
        expect_csr("mscratch", csr_pkg::addr_mscratch, val);
        modify_csr(csr_pkg::cmd_clear, csr_pkg::addr_mscratch, 32'h00ff_0f00);
        val = val & ~32'h00ff_0f00;
        expect_csr("mscratch", csr_pkg::addr_mscratch, val);
        modify_csr(csr_pkg::cmd_write, csr_pkg::addr_mepc, 32'h1234_5677);
        expect_csr("mepc", csr_pkg::addr_mepc, 32'h1234_5674); // Low two bits dropped
        modify_csr(csr_pkg::cmd_write, csr_pkg::addr_sscratch, sval);
        expect_csr("sscratch", csr_pkg::addr_sscratch, sval);
        expect_csr("mscratch", csr_pkg::addr_mscratch, val);
        report_test("read_write_set_clear");
    endtask

    task automatic machine_ecall();
        apply_reset();
        compare("trap_vector", trap_vector, 32'h0);
        modify_csr(csr_pkg::cmd_write, csr_pkg::addr_mtvec, 32'h0000_2000); // Direct
        run_cmd(csr_pkg::cmd_ecall, 32'h0000_0124, 1'b1);
        compare("trap_vector", trap_vector, 32'h0000_2000);
        expect_csr("mcause", csr_pkg::addr_mcause, 32'd11);   // 8 plus machine 3
        expect_csr("mepc", csr_pkg::addr_mepc, 32'h0000_0124);
        expect_csr("mstatus", csr_pkg::addr_mstatus, 32'h0000_1800); // mpp machine
        report_test("machine_ecall");
    endtask

    task automatic mret_user_access();
        apply_reset();
        modify_csr(csr_pkg::cmd_write, csr_pkg::addr_mtvec, 32'h0000_3000);
        modify_csr(csr_pkg::cmd_write, csr_pkg::addr_mscratch, 32'hcafe_0042);
        modify_csr(csr_pkg::cmd_write, csr_pkg::addr_mepc, 32'h0000_0800);
        modify_csr(csr_pkg::cmd_write, csr_pkg::addr_mstatus, 32'h0); // mpp user
        run_cmd(csr_pkg::cmd_mret, 32'h0000_0200, 1'b1);
        compare("trap_vector", trap_vector, 32'h0000_0800);
        expect_csr("mscratch", csr_pkg::addr_mscratch, 32'h0); // Denied in user mode
        modify_csr(csr_pkg::cmd_write, csr_pkg::addr_mscratch, 32'h1111_2222);
        run_cmd(csr_pkg::cmd_ecall, 32'h0000_0810, 1'b1);
        compare("trap_vector", trap_vector, 32'h0000_3000);
        expect_csr("mcause", csr_pkg::addr_mcause, 32'd8);
        expect_csr("mscratch", csr_pkg::addr_mscratch, 32'hcafe_0042);
        report_test("mret_user_access");
    endtask

    task automatic delegated_ecall();
        apply_reset();
        modify_csr(csr_pkg::cmd_write, csr_pkg::addr_stvec, 32'h0000_5000);
        modify_csr(csr_pkg::cmd_write, csr_pkg::addr_medeleg, 32'h0000_0100); // User ecall
        modify_csr(csr_pkg::cmd_write, csr_pkg::addr_mepc, 32'h0000_0900);
        modify_csr(csr_pkg::cmd_write, csr_pkg::addr_mstatus, 32'h0);
        run_cmd(csr_pkg::cmd_mret, 32'h0000_0100, 1'b1);
        compare("trap_vector", trap_vector, 32'h0000_0900);
        run_cmd(csr_pkg::cmd_ecall, 32'h0000_0a40, 1'b1);
        compare("trap_vector", trap_vector, 32'h0000_5000);
        expect_csr("scause", csr_pkg::addr_scause, 32'd8);
        expect_csr("sepc", csr_pkg::addr_sepc, 32'h0000_0a40);
        expect_csr("sstatus", csr_pkg::addr_sstatus, 32'h0); // spp user, sie and spie 0
        run_cmd(csr_pkg::cmd_sret, 32'h0000_5010, 1'b1);
        compare("trap_vector", trap_vector, 32'h0000_0a40);
        report_test("delegated_ecall");
    endtask

    task automatic vectored_timer_irq();
        logic [31:0] base;
        logic [31:0] rd;
        apply_reset();
        base = 32'h0000_4100;
        modify_csr(csr_pkg::cmd_write, csr_pkg::addr_mtvec, base | 32'h1); // Vectored
        modify_csr(csr_pkg::cmd_write, csr_pkg::addr_mie, 32'h0000_0080);   // mtie
        modify_csr(csr_pkg::cmd_set, csr_pkg::addr_mstatus, 32'h0000_0008); // mie
        set_timer(1'b1);
        run_cmd(csr_pkg::cmd_none, 32'h0000_0300, 1'b0); // Samples mtip only
        run_cmd(csr_pkg::cmd_none, 32'h0000_0304, 1'b1);
        compare("trap_vector", trap_vector, base + 32'd28); // Cause 7 times 4
        expect_csr("mcause", csr_pkg::addr_mcause, 32'h8000_0007);
        expect_csr("mepc", csr_pkg::addr_mepc, 32'h0000_0304);
        read_csr(csr_pkg::addr_mstatus, rd);
        compare("mstatus.mie", {31'b0, rd[3]}, 32'h0);
        compare("mstatus.mpie", {31'b0, rd[7]}, 32'h1);
        report_test("vectored_timer_irq");
    endtask

    task automatic delegated_soft_irq();
        apply_reset();
        modify_csr(csr_pkg::cmd_write, csr_pkg::addr_stvec, 32'h0000_6000);
        modify_csr(csr_pkg::cmd_write, csr_pkg::addr_mideleg, 32'h0000_0002);
        modify_csr(csr_pkg::cmd_write, csr_pkg::addr_mie, 32'h0000_0002);
        modify_csr(csr_pkg::cmd_write, csr_pkg::addr_mepc, 32'h0000_0a00);
        modify_csr(csr_pkg::cmd_write, csr_pkg::addr_mstatus, 32'h0);
        modify_csr(csr_pkg::cmd_write, csr_pkg::addr_mip, 32'h0000_0002); // Held off in M
        run_cmd(csr_pkg::cmd_mret, 32'h0000_0100, 1'b1);
        compare("trap_vector", trap_vector, 32'h0000_0a00);
        run_cmd(csr_pkg::cmd_none, 32'h0000_0a00, 1'b1); // Taken in user mode
        compare("trap_vector", trap_vector, 32'h0000_6000);
        expect_csr("scause", csr_pkg::addr_scause, 32'h8000_0001);
        expect_csr("sepc", csr_pkg::addr_sepc, 32'h0000_0a00);
        report_test("delegated_soft_irq");
    endtask

    initial begin
        seed        = 32'h5ad4_8faa;
        clk         = 1'b0;
        arst_n      = 1'b0;
        valid       = 1'b0;
        pc          = '0;
        cmd         = csr_pkg::cmd_none;
        csr_addr    = '0;
        op1_data    = '0;
        mtime       = '0;
        mtimecmp    = '1;
        errors      = 0;
        checks      = 0;
        test_errors = 0;
        rw_set_clear();
        machine_ecall();
        mret_user_access();
        delegated_ecall();
        vectored_timer_irq();
        delegated_soft_irq();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
